// File: include/cpu_defs.svh
/*
 * Back-end constants: operation codes for loads, stores and writeback
 * sources, exception codes and the data RAM size.
 */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// load kinds
`define LD_NONE   3'd0
`define LD_B      3'd1
`define LD_BU     3'd2
`define LD_H      3'd3
`define LD_HU     3'd4
`define LD_W      3'd5

// store kinds
`define ST_NONE   2'd0
`define ST_B      2'd1
`define ST_H      2'd2
`define ST_W      2'd3

// writeback sources
`define WB_ALU    2'd0
`define WB_LOAD   2'd1
`define WB_LINK   2'd2

// exception codes, all ones means no exception
`define EXC_NONE  5'h1f
`define EXC_ADEL  5'd4
`define EXC_ADES  5'd5
`define EXC_OV    5'd12

// word address width of the data RAM
`define DRAM_ADDR_W 10

`endif

// File: src/cpuPkg.sv
/*
 * Shared vector types of the memory back end.
 */
package cpuPkg;

    // data word or byte address
    typedef logic [31:0] word_t;

    typedef logic [4:0] regAddr_t;

    typedef logic [4:0] excCode_t;

    // load and store kinds and writeback source
    typedef logic [2:0] loadType_t;
    typedef logic [1:0] storeType_t;
    typedef logic [1:0] wbSel_t;

    // one enable per byte lane with lane 0 at bits 7:0
    typedef logic [3:0] byteEn_t;

endpackage

// File: src/storeAlign.sv
/*
 * MEM-stage store alignment. Checks load and store alignment, merges the
 * result with an incoming exception, and forms RAM byte enables and lanes.
 */
`timescale 1ns/10ps
`include "cpu_defs.svh"

module storeAlign (
    input  cpuPkg::word_t               memAluOut,
    input  cpuPkg::word_t               memStoreData,
    input  cpuPkg::storeType_t          memStoreType,
    input  cpuPkg::loadType_t           memLoadType,
    input  cpuPkg::excCode_t            memExcIn,
    input  logic                        memRegWr,
    input  logic                        hold,
    input  logic                        flush,
    output logic                        ramWe,
    output cpuPkg::byteEn_t             ramByteEn,
    output logic [`DRAM_ADDR_W-1:0]     ramAddr,
    output cpuPkg::word_t               ramWrData,
    output cpuPkg::excCode_t            memExcFinal,
    output logic                        memRegWrFinal
);

    cpuPkg::excCode_t excNew;
    logic             excAny;

    // misalignment detection
    always_comb begin
        excNew = `EXC_NONE;
        if ((memLoadType == `LD_H || memLoadType == `LD_HU) && memAluOut[0]) begin
            excNew = `EXC_ADEL;
        end
        if (memLoadType == `LD_W && memAluOut[1:0] != 2'b00) begin
            excNew = `EXC_ADEL;
        end
        if (memStoreType == `ST_H && memAluOut[0]) begin
            excNew = `EXC_ADES;
        end
        if (memStoreType == `ST_W && memAluOut[1:0] != 2'b00) begin
            excNew = `EXC_ADES;
        end
    end

    // an exception from an earlier stage wins
    assign memExcFinal   = (memExcIn != `EXC_NONE) ? memExcIn : excNew;
    assign excAny        = (memExcFinal != `EXC_NONE);
    assign memRegWrFinal = memRegWr && !excAny;

    assign ramWe   = (memStoreType != `ST_NONE) && !excAny && !hold && !flush;
    assign ramAddr = memAluOut[`DRAM_ADDR_W+1:2];

    // lane replication and byte enables
    always_comb begin
        case (memStoreType)
            `ST_B: begin
                ramByteEn = 4'b0001 << memAluOut[1:0];
                ramWrData = {4{memStoreData[7:0]}};
            end
            `ST_H: begin
                ramByteEn = memAluOut[1] ? 4'b1100 : 4'b0011;
                ramWrData = {2{memStoreData[15:0]}};
            end
            `ST_W: begin
                ramByteEn = 4'b1111;
                ramWrData = memStoreData;
            end
            default: begin
                ramByteEn = 4'b0000;
                ramWrData = memStoreData;
            end
        endcase
    end

endmodule

// File: src/dataRam.sv
/*
 * Byte-writable synchronous data RAM. The read word is registered and
 * keeps its value while the read port is held.
 */
`timescale 1ns/10ps
`include "cpu_defs.svh"

module dataRam (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        we,
    input  cpuPkg::byteEn_t             byteEn,
    input  logic [`DRAM_ADDR_W-1:0]     addr,
    input  cpuPkg::word_t               wrData,
    input  logic                        rdHold,
    output cpuPkg::word_t               rdData
);

    localparam int Depth = 1 << `DRAM_ADDR_W;

    cpuPkg::word_t mem [Depth];

    // byte lane writes
    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (byteEn[i]) begin
                    mem[addr][i*8 +: 8] <= wrData[i*8 +: 8];
                end
            end
        end
    end

    // read before write on the same address
    always_ff @(posedge clk) begin
        if (!rstN) begin
            rdData <= '0;
        end else if (!rdHold) begin
            rdData <= mem[addr];
        end
    end

endmodule

// File: src/mem2Reg.sv
/*
 * MEM to MEM2 pipeline register. Flush and reset load a bubble,
 * hold keeps the current instruction.
 */
`timescale 1ns/10ps
`include "cpu_defs.svh"

module mem2Reg (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        flush,
    input  logic                        hold,
    input  cpuPkg::word_t               memAluOut,
    input  cpuPkg::word_t               memPc,
    input  cpuPkg::regAddr_t            memDst,
    input  cpuPkg::wbSel_t              memWbSel,
    input  logic                        memRegWrFinal,
    input  cpuPkg::excCode_t            memExcFinal,
    input  logic                        memInDelaySlot,
    input  cpuPkg::loadType_t           memLoadType,
    output cpuPkg::word_t               mem2AluOut,
    output cpuPkg::word_t               mem2Pc,
    output cpuPkg::regAddr_t            mem2Dst,
    output cpuPkg::wbSel_t              mem2WbSel,
    output logic                        mem2RegWr,
    output cpuPkg::excCode_t            mem2Exc,
    output logic                        mem2InDelaySlot,
    output cpuPkg::loadType_t           mem2LoadType
);

    // flush beats hold
    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            mem2AluOut      <= '0;
            mem2Pc          <= '0;
            mem2Dst         <= '0;
            mem2WbSel       <= `WB_ALU;
            mem2RegWr       <= 1'b0;
            mem2Exc         <= `EXC_NONE;
            mem2InDelaySlot <= 1'b0;
            mem2LoadType    <= `LD_NONE;
        end else if (!hold) begin
            mem2AluOut      <= memAluOut;
            mem2Pc          <= memPc;
            mem2Dst         <= memDst;
            mem2WbSel       <= memWbSel;
            mem2RegWr       <= memRegWrFinal;
            mem2Exc         <= memExcFinal;
            mem2InDelaySlot <= memInDelaySlot;
            mem2LoadType    <= memLoadType;
        end
    end

endmodule

// File: src/loadAlign.sv
/*
 * MEM2-stage load alignment. Picks the addressed byte or halfword of the
 * RAM word and extends it by load kind.
 */
`timescale 1ns/10ps
`include "cpu_defs.svh"

module loadAlign (
    input  logic [1:0]                  mem2AluOut,
    input  cpuPkg::loadType_t           mem2LoadType,
    input  cpuPkg::word_t               ramRdData,
    output cpuPkg::word_t               loadData
);

    logic [7:0]  byteLane;
    logic [15:0] halfLane;

    // lane select from the low address bits
    always_comb begin
        case (mem2AluOut)
            2'd0:    byteLane = ramRdData[7:0];
            2'd1:    byteLane = ramRdData[15:8];
            2'd2:    byteLane = ramRdData[23:16];
            default: byteLane = ramRdData[31:24];
        endcase
    end

    assign halfLane = mem2AluOut[1] ? ramRdData[31:16] : ramRdData[15:0];

    always_comb begin
        case (mem2LoadType)
            `LD_B:   loadData = {{24{byteLane[7]}}, byteLane};
            `LD_BU:  loadData = {24'd0, byteLane};
            `LD_H:   loadData = {{16{halfLane[15]}}, halfLane};
            `LD_HU:  loadData = {16'd0, halfLane};
            // full word, also the don't-care case of non-loads
            default: loadData = ramRdData;
        endcase
    end

endmodule

// File: src/wbStage.sv
/*
 * Writeback stage. Selects the result source, forms the exception report
 * with EPC and bad address, and registers both into WB.
 */
`timescale 1ns/10ps
`include "cpu_defs.svh"

module wbStage (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        hold,
    input  cpuPkg::word_t               mem2AluOut,
    input  cpuPkg::word_t               mem2Pc,
    input  cpuPkg::regAddr_t            mem2Dst,
    input  cpuPkg::wbSel_t              mem2WbSel,
    input  logic                        mem2RegWr,
    input  cpuPkg::excCode_t            mem2Exc,
    input  logic                        mem2InDelaySlot,
    input  cpuPkg::word_t               loadData,
    output logic                        wbEn,
    output cpuPkg::regAddr_t            wbDst,
    output cpuPkg::word_t               wbData,
    output logic                        excValid,
    output cpuPkg::excCode_t            excCode,
    output cpuPkg::word_t               excPc,
    output cpuPkg::word_t               badVAddr
);

    cpuPkg::word_t resultSel;
    logic          excHit;

    always_comb begin
        case (mem2WbSel)
            `WB_LOAD: resultSel = loadData;
            // return address skips the delay slot
            `WB_LINK: resultSel = mem2Pc + 32'd8;
            default:  resultSel = mem2AluOut;
        endcase
    end

    assign excHit = (mem2Exc != `EXC_NONE);

    // valid bits, a held edge inserts a bubble
    always_ff @(posedge clk) begin
        if (!rstN || hold) begin
            wbEn     <= 1'b0;
            excValid <= 1'b0;
        end else begin
            wbEn     <= mem2RegWr && !excHit;
            excValid <= excHit;
        end
    end

    always_ff @(posedge clk) begin
        wbDst   <= mem2Dst;
        wbData  <= resultSel;
        excCode <= mem2Exc;
        // EPC points at the branch for a delay-slot instruction
        excPc   <= mem2InDelaySlot ? mem2Pc - 32'd4 : mem2Pc;
        if (mem2Exc == `EXC_ADEL || mem2Exc == `EXC_ADES) begin
            badVAddr <= mem2AluOut;
        end else begin
            badVAddr <= '0;
        end
    end

endmodule

// File: src/memBackEnd.sv
/*
 * Memory back end of the integer pipeline. Runs MEM store alignment, the
 * data RAM, the MEM2 register, load alignment and the WB register.
 */
`timescale 1ns/10ps
`include "cpu_defs.svh"

module memBackEnd (
    input  logic                        clk,
    input  logic                        rstN,
    input  cpuPkg::word_t               memAluOut,
    input  cpuPkg::word_t               memPc,
    input  cpuPkg::word_t               memStoreData,
    input  cpuPkg::regAddr_t            memDst,
    input  cpuPkg::wbSel_t              memWbSel,
    input  logic                        memRegWr,
    input  cpuPkg::loadType_t           memLoadType,
    input  cpuPkg::storeType_t          memStoreType,
    input  cpuPkg::excCode_t            memExcIn,
    input  logic                        memInDelaySlot,
    input  logic                        hold,
    input  logic                        flush,
    output logic                        wbEn,
    output cpuPkg::regAddr_t            wbDst,
    output cpuPkg::word_t               wbData,
    output logic                        excValid,
    output cpuPkg::excCode_t            excCode,
    output cpuPkg::word_t               excPc,
    output cpuPkg::word_t               badVAddr
);

    // MEM stage to RAM
    logic                        ramWe;
    cpuPkg::byteEn_t             ramByteEn;
    logic [`DRAM_ADDR_W-1:0]     ramAddr;
    cpuPkg::word_t               ramWrData;
    cpuPkg::word_t               ramRdData;
    cpuPkg::excCode_t            memExcFinal;
    logic                        memRegWrFinal;

    // MEM2 stage fields
    cpuPkg::word_t               mem2AluOut;
    cpuPkg::word_t               mem2Pc;
    cpuPkg::regAddr_t            mem2Dst;
    cpuPkg::wbSel_t              mem2WbSel;
    logic                        mem2RegWr;
    cpuPkg::excCode_t            mem2Exc;
    logic                        mem2InDelaySlot;
    cpuPkg::loadType_t           mem2LoadType;
    cpuPkg::word_t               loadData;

    storeAlign storeAlign_inst (
        .memAluOut     (memAluOut),
        .memStoreData  (memStoreData),
        .memStoreType  (memStoreType),
        .memLoadType   (memLoadType),
        .memExcIn      (memExcIn),
        .memRegWr      (memRegWr),
        .hold          (hold),
        .flush         (flush),
        .ramWe         (ramWe),
        .ramByteEn     (ramByteEn),
        .ramAddr       (ramAddr),
        .ramWrData     (ramWrData),
        .memExcFinal   (memExcFinal),
        .memRegWrFinal (memRegWrFinal)
    );

    // read register stalls together with MEM2
    dataRam dataRam_inst (
        .clk    (clk),
        .rstN   (rstN),
        .we     (ramWe),
        .byteEn (ramByteEn),
        .addr   (ramAddr),
        .wrData (ramWrData),
        .rdHold (hold),
        .rdData (ramRdData)
    );

    mem2Reg mem2Reg_inst (
        .clk             (clk),
        .rstN            (rstN),
        .flush           (flush),
        .hold            (hold),
        .memAluOut       (memAluOut),
        .memPc           (memPc),
        .memDst          (memDst),
        .memWbSel        (memWbSel),
        .memRegWrFinal   (memRegWrFinal),
        .memExcFinal     (memExcFinal),
        .memInDelaySlot  (memInDelaySlot),
        .memLoadType     (memLoadType),
        .mem2AluOut      (mem2AluOut),
        .mem2Pc          (mem2Pc),
        .mem2Dst         (mem2Dst),
        .mem2WbSel       (mem2WbSel),
        .mem2RegWr       (mem2RegWr),
        .mem2Exc         (mem2Exc),
        .mem2InDelaySlot (mem2InDelaySlot),
        .mem2LoadType    (mem2LoadType)
    );

    loadAlign loadAlign_inst (
        .mem2AluOut   (mem2AluOut[1:0]),
        .mem2LoadType (mem2LoadType),
        .ramRdData    (ramRdData),
        .loadData     (loadData)
    );

    wbStage wbStage_inst (
        .clk             (clk),
        .rstN            (rstN),
        .hold            (hold),
        .mem2AluOut      (mem2AluOut),
        .mem2Pc          (mem2Pc),
        .mem2Dst         (mem2Dst),
        .mem2WbSel       (mem2WbSel),
        .mem2RegWr       (mem2RegWr),
        .mem2Exc         (mem2Exc),
        .mem2InDelaySlot (mem2InDelaySlot),
        .loadData        (loadData),
        .wbEn            (wbEn),
        .wbDst           (wbDst),
        .wbData          (wbData),
        .excValid        (excValid),
        .excCode         (excCode),
        .excPc           (excPc),
        .badVAddr        (badVAddr)
    );

endmodule

// File: verif/wbChecker.sv
/*
 * Result checker. Queues the expected writebacks and exceptions in order
 * and compares them with the DUT's WB outputs.
 */
`timescale 1ns/10ps

module wbChecker (
    input  logic                clk,
    input  logic                rstN,
    input  logic                pushValid,
    input  logic                pushIsExc,
    input  logic [127:0]        pushName,
    input  cpuPkg::regAddr_t    pushDst,
    input  cpuPkg::word_t       pushData,
    input  cpuPkg::excCode_t    pushCode,
    input  cpuPkg::word_t       pushPc,
    input  cpuPkg::word_t       pushBad,
    input  logic                endOfTest,
    input  logic                wbEn,
    input  cpuPkg::regAddr_t    wbDst,
    input  cpuPkg::word_t       wbData,
    input  logic                excValid,
    input  cpuPkg::excCode_t    excCode,
    input  cpuPkg::word_t       excPc,
    input  cpuPkg::word_t       badVAddr,
    output int                  valueErrors,
    output int                  flowErrors
);

    typedef struct packed {
        logic [127:0]       name;
        logic               isExc;
        cpuPkg::regAddr_t   dst;
        cpuPkg::word_t      data;
        cpuPkg::excCode_t   code;
        cpuPkg::word_t      pc;
        cpuPkg::word_t      bad;
    } expect_t;

    expect_t expQ [$];
    int      valueCount = 0;
    int      flowCount = 0;

    assign valueErrors = valueCount;
    assign flowErrors  = flowCount;

    task automatic checkField(input logic [127:0] name, input string field,
                              input cpuPkg::word_t expVal, input cpuPkg::word_t actVal);
        if (actVal !== expVal) begin
            $display("error: row %0s %0s expected %h actual %h", name, field, expVal, actVal);
            valueCount++;
        end
    endtask

    // outputs are stable at the rising edge, compare before taking new entries
    always @(posedge clk) begin
        expect_t e;
        if (rstN && (wbEn || excValid)) begin
            if (wbEn && excValid) begin
                $display("writeback and exception were reported in the same cycle");
                flowCount++;
            end else if (expQ.size() == 0) begin
                $display("a result appeared while no instruction was pending");
                flowCount++;
            end else begin
                e = expQ.pop_front();
                if (e.isExc != excValid) begin
                    $display("error: row %0s result expected %0s actual %0s", e.name,
                             e.isExc ? "exception" : "writeback",
                             excValid ? "exception" : "writeback");
                    valueCount++;
                end else if (excValid) begin
                    checkField(e.name, "excCode", {27'd0, e.code}, {27'd0, excCode});
                    checkField(e.name, "excPc", e.pc, excPc);
                    checkField(e.name, "badVAddr", e.bad, badVAddr);
                end else begin
                    checkField(e.name, "wbDst", {27'd0, e.dst}, {27'd0, wbDst});
                    checkField(e.name, "wbData", e.data, wbData);
                end
            end
        end
        if (pushValid) begin
            expQ.push_back({pushName, pushIsExc, pushDst, pushData, pushCode, pushPc, pushBad});
        end
        if (endOfTest && expQ.size() != 0) begin
            $display("%0d expected results never appeared", expQ.size());
            flowCount += expQ.size();
            expQ.delete();
        end
    end

endmodule

// File: verif/memBackEndTb.sv
/*
 * Testbench of the memory back end. Applies a table of MEM-stage rows twice,
 * the second pass under random hold, and hands expected results to the checker.
 */
`timescale 1ns/10ps
`include "cpu_defs.svh"

module memBackEndTb;

    logic                   clk;
    logic                   rstN;
    cpuPkg::word_t          memAluOut;
    cpuPkg::word_t          memPc;
    cpuPkg::word_t          memStoreData;
    cpuPkg::regAddr_t       memDst;
    cpuPkg::wbSel_t         memWbSel;
    logic                   memRegWr;
    cpuPkg::loadType_t      memLoadType;
    cpuPkg::storeType_t     memStoreType;
    cpuPkg::excCode_t       memExcIn;
    logic                   memInDelaySlot;
    logic                   hold;
    logic                   flush;
    logic                   wbEn;
    cpuPkg::regAddr_t       wbDst;
    cpuPkg::word_t          wbData;
    logic                   excValid;
    cpuPkg::excCode_t       excCode;
    cpuPkg::word_t          excPc;
    cpuPkg::word_t          badVAddr;

    // expected result handed to the checker
    logic                   pushValid;
    logic                   pushIsExc;
    logic [127:0]           pushName;
    cpuPkg::regAddr_t       pushDst;
    cpuPkg::word_t          pushData;
    cpuPkg::excCode_t       pushCode;
    cpuPkg::word_t          pushPc;
    cpuPkg::word_t          pushBad;
    logic                   endOfTest;
    int                     valueErrors;
    int                     flowErrors;

    logic [31:0]            lcgState = 32'h154a;

    // MEM inputs of one row and its expected result
    typedef struct packed {
        logic [127:0]       name;
        cpuPkg::word_t      alu;
        cpuPkg::word_t      pc;
        cpuPkg::word_t      data;
        cpuPkg::regAddr_t   dst;
        cpuPkg::wbSel_t     sel;
        logic               regWr;
        cpuPkg::loadType_t  ld;
        cpuPkg::storeType_t st;
        cpuPkg::excCode_t   exc;
        logic               slot;
        logic               flush;
        logic               expValid;
        logic               expExc;
        cpuPkg::word_t      expData;
        cpuPkg::excCode_t   expCode;
        cpuPkg::word_t      expPc;
        cpuPkg::word_t      expBad;
    } tableRow_t;

    tableRow_t rows [$];

    memBackEnd memBackEnd_inst (.*);

    wbChecker wbChecker_inst (.*);

    function automatic logic [31:0] nextRand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // a bubble that expects nothing
    function automatic tableRow_t blankRow(input logic [127:0] name);
        tableRow_t r;
        r      = '0;
        r.name = name;
        r.sel  = `WB_ALU;
        r.ld   = `LD_NONE;
        r.st   = `ST_NONE;
        r.exc  = `EXC_NONE;
        return r;
    endfunction

    // value is the store data of a store or the extended word a load returns
    task automatic addMem(input logic [127:0] name, input cpuPkg::loadType_t ld,
                          input cpuPkg::storeType_t st, input cpuPkg::word_t addr,
                          input cpuPkg::word_t value, input cpuPkg::regAddr_t dst);
        tableRow_t r;
        r     = blankRow(name);
        r.alu = addr;
        r.ld  = ld;
        r.st  = st;
        if (st != `ST_NONE) begin
            r.data = value;
        end else begin
            r.regWr    = 1'b1;
            r.sel      = `WB_LOAD;
            r.dst      = dst;
            r.expValid = 1'b1;
            r.expData  = value;
        end
        rows.push_back(r);
    endtask

    task automatic addAlu(input logic [127:0] name, input cpuPkg::wbSel_t sel,
                          input logic regWr, input cpuPkg::word_t value,
                          input cpuPkg::word_t pc, input cpuPkg::regAddr_t dst,
                          input cpuPkg::word_t expData);
        tableRow_t r;
        r          = blankRow(name);
        r.sel      = sel;
        r.regWr    = regWr;
        r.alu      = value;
        r.pc       = pc;
        r.dst      = dst;
        r.expValid = regWr;
        r.expData  = expData;
        rows.push_back(r);
    endtask

    // faulting loads still ask for a register write
    task automatic addFault(input logic [127:0] name, input cpuPkg::loadType_t ld,
                            input cpuPkg::storeType_t st, input cpuPkg::word_t addr,
                            input cpuPkg::excCode_t excIn, input cpuPkg::word_t pc,
                            input logic slot, input cpuPkg::excCode_t code,
                            input cpuPkg::word_t epc, input cpuPkg::word_t bad);
        tableRow_t r;
        r          = blankRow(name);
        r.alu      = addr;
        r.ld       = ld;
        r.st       = st;
        r.exc      = excIn;
        r.pc       = pc;
        r.slot     = slot;
        r.regWr    = (st == `ST_NONE);
        r.sel      = `WB_LOAD;
        r.dst      = 5'd20;
        r.data     = 32'hdead_beef;
        r.expValid = 1'b1;
        r.expExc   = 1'b1;
        r.expCode  = code;
        r.expPc    = epc;
        r.expBad   = bad;
        rows.push_back(r);
    endtask

    // store that also asks for a register write, only the flush stops both
    task automatic addFlush(input logic [127:0] name, input cpuPkg::word_t addr,
                            input cpuPkg::word_t data);
        tableRow_t r;
        r       = blankRow(name);
        r.alu   = addr;
        r.st    = `ST_W;
        r.data  = data;
        r.regWr = 1'b1;
        r.dst   = 5'd21;
        r.flush = 1'b1;
        rows.push_back(r);
    endtask

    task automatic buildTable();
        // word 0x100 lanes and a load right behind its store
        addMem("sw w0", `LD_NONE, `ST_W, 32'h100, 32'h8899_aabb, 5'd0);
        addMem("lw w0", `LD_W, `ST_NONE, 32'h100, 32'h8899_aabb, 5'd2);
        addMem("lb lane0", `LD_B, `ST_NONE, 32'h100, 32'hffff_ffbb, 5'd3);
        addMem("lbu lane1", `LD_BU, `ST_NONE, 32'h101, 32'h0000_00aa, 5'd4);
        addMem("lb lane2", `LD_B, `ST_NONE, 32'h102, 32'hffff_ff99, 5'd5);
        addMem("lbu lane3", `LD_BU, `ST_NONE, 32'h103, 32'h0000_0088, 5'd6);
        addMem("lh low", `LD_H, `ST_NONE, 32'h100, 32'hffff_aabb, 5'd7);
        addMem("lhu high", `LD_HU, `ST_NONE, 32'h102, 32'h0000_8899, 5'd8);
        // word 0x104 built from a word, a halfword and a byte store
        addMem("sw w1", `LD_NONE, `ST_W, 32'h104, 32'h1122_3344, 5'd0);
        addMem("sh w1 high", `LD_NONE, `ST_H, 32'h106, 32'hcafe_7f01, 5'd0);
        addMem("sb w1 lane1", `LD_NONE, `ST_B, 32'h105, 32'h0000_00e5, 5'd0);
        addMem("lw w1", `LD_W, `ST_NONE, 32'h104, 32'h7f01_e544, 5'd9);
        addMem("lh w1 high", `LD_H, `ST_NONE, 32'h106, 32'h0000_7f01, 5'd10);
        addMem("lh w1 low", `LD_H, `ST_NONE, 32'h104, 32'hffff_e544, 5'd11);
        addMem("lhu w1 low", `LD_HU, `ST_NONE, 32'h104, 32'h0000_e544, 5'd12);
        addMem("lb w1 lane1", `LD_B, `ST_NONE, 32'h105, 32'hffff_ffe5, 5'd13);
        addMem("sb w0 lane3", `LD_NONE, `ST_B, 32'h103, 32'h0000_007c, 5'd0);
        addMem("lb w0 lane3", `LD_B, `ST_NONE, 32'h103, 32'h0000_007c, 5'd14);
        addAlu("alu add", `WB_ALU, 1'b1, 32'h1234_5678, 32'h0040_0040, 5'd15, 32'h1234_5678);
        addAlu("link jal", `WB_LINK, 1'b1, 32'h0, 32'h0040_0044, 5'd31, 32'h0040_004c);
        addAlu("alu no write", `WB_ALU, 1'b0, 32'h5555_5555, 32'h0040_0048, 5'd16, 32'h0);
        addAlu("bubble", `WB_ALU, 1'b0, 32'h0, 32'h0, 5'd0, 32'h0);
        addFault("lw misalign", `LD_W, `ST_NONE, 32'h102, `EXC_NONE, 32'h0040_0100, 1'b0,
                 `EXC_ADEL, 32'h0040_0100, 32'h102);
        addFault("lh misalign", `LD_H, `ST_NONE, 32'h101, `EXC_NONE, 32'h0040_0104, 1'b0,
                 `EXC_ADEL, 32'h0040_0104, 32'h101);
        addFault("sw misalign", `LD_NONE, `ST_W, 32'h101, `EXC_NONE, 32'h0040_0108, 1'b0,
                 `EXC_ADES, 32'h0040_0108, 32'h101);
        addFault("sh slot misalign", `LD_NONE, `ST_H, 32'h103, `EXC_NONE, 32'h0040_010c, 1'b1,
                 `EXC_ADES, 32'h0040_0108, 32'h103);
        // faulting stores left word 0x100 alone
        addMem("lw after fault", `LD_W, `ST_NONE, 32'h100, 32'h7c99_aabb, 5'd17);
        addFault("ov over adel", `LD_W, `ST_NONE, 32'h102, `EXC_OV, 32'h0040_0110, 1'b0,
                 `EXC_OV, 32'h0040_0110, 32'h0);
        addFault("ov in slot", `LD_NONE, `ST_NONE, 32'h7fff_ffff, `EXC_OV, 32'h0040_0118,
                 1'b1, `EXC_OV, 32'h0040_0114, 32'h0);
        addAlu("before flush", `WB_ALU, 1'b1, 32'ha5a5_a5a5, 32'h0040_0120, 5'd18,
               32'ha5a5_a5a5);
        addFlush("sw flushed", 32'h100, 32'h0);
        addMem("lw after flush", `LD_W, `ST_NONE, 32'h100, 32'h7c99_aabb, 5'd19);
    endtask

    task automatic driveRow(input tableRow_t r);
        memAluOut      <= r.alu;
        memPc          <= r.pc;
        memStoreData   <= r.data;
        memDst         <= r.dst;
        memWbSel       <= r.sel;
        memRegWr       <= r.regWr;
        memLoadType    <= r.ld;
        memStoreType   <= r.st;
        memExcIn       <= r.exc;
        memInDelaySlot <= r.slot;
        flush          <= r.flush;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // four edges per row and pass plus reset and drain
    initial begin
        int limit;
        #1;
        limit = rows.size() * 2 * 4 + 50;
        repeat (limit) @(posedge clk);
        $display("timeout: results did not complete within %0d cycles", limit);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        tableRow_t r;
        logic      h;
        logic      accepted;
        buildTable();
        driveRow(blankRow("idle"));
        rstN      <= 1'b0;
        hold      <= 1'b0;
        pushValid <= 1'b0;
        pushIsExc <= 1'b0;
        pushName  <= '0;
        pushDst   <= '0;
        pushData  <= '0;
        pushCode  <= '0;
        pushPc    <= '0;
        pushBad   <= '0;
        endOfTest <= 1'b0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        // idle bubbles before the first row
        repeat (3) @(posedge clk);

        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < rows.size(); i++) begin
                r = rows[i];
                driveRow(r);
                accepted = 1'b0;
                while (!accepted) begin
                    lcgState = nextRand(lcgState);
                    h = (pass == 1) && !r.flush && (lcgState[31:30] == 2'b00);
                    hold <= h;
                    @(posedge clk);
                    pushValid <= 1'b0;
                    if (!h) begin
                        accepted = 1'b1;
                        if (r.expValid) begin
                            pushValid <= 1'b1;
                            pushIsExc <= r.expExc;
                            pushName  <= r.name;
                            pushDst   <= r.dst;
                            pushData  <= r.expData;
                            pushCode  <= r.expCode;
                            pushPc    <= r.expPc;
                            pushBad   <= r.expBad;
                        end
                    end
                end
            end
        end

        driveRow(blankRow("drain"));
        hold <= 1'b0;
        @(posedge clk);
        pushValid <= 1'b0;
        repeat (4) @(posedge clk);
        endOfTest <= 1'b1;
        repeat (2) @(posedge clk);
        $display("errors: %0d value mismatches, %0d missing or unexpected results",
                 valueErrors, flowErrors);
        if (valueErrors == 0 && flowErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
src/cpuPkg.sv
src/storeAlign.sv
src/dataRam.sv
src/mem2Reg.sv
src/loadAlign.sv
src/wbStage.sv
src/memBackEnd.sv
verif/wbChecker.sv
verif/memBackEndTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module memBackEndTb -f filelist.f

out=$(./obj_dir/VmemBackEndTb)
echo "$out"
echo "$out" | grep -qx "Test OK"
